//--- Bender.yml
package:
  name: sudokuSolver

sources:
  - files:
      - logic/sudokuPkg.sv
      - logic/sudokuCell.sv
      - logic/peerRouter.sv
      - logic/groupChecker.sv
      - logic/solverStatus.sv
      - logic/sudokuSolver.sv
  - target: test
    files:
      - bench/sudokuSolverTb.sv

//--- bench/sudokuSolverTb.sv
module sudokuSolverTb
   import sudokuPkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          WAIT_LIMIT = 2000;  // cycles per wait
   localparam logic [31:0] SEED       = 32'hec3e_69dc;

   logic       clk = 1'b0;
   logic       rst;
   logic       start;
   gridFlat_t  inGrid;
   gridFlat_t  outGrid;
   cellCount_t unsolvedCells;
   logic       allDone;
   logic       anyChanged;
   logic       anyError;
   logic       timeOut;

   int fd;
   int recordCount;
   int puzzle [N_CELLS];    // 0 for a blank cell
   int solution [N_CELLS];

   sudokuSolver #(
      .STALL_LIMIT (4)
   ) dut (
      .clk           (clk),
      .rst           (rst),
      .start         (start),
      .inGrid        (inGrid),
      .outGrid       (outGrid),
      .unsolvedCells (unsolvedCells),
      .allDone       (allDone),
      .anyChanged    (anyChanged),
      .anyError      (anyError),
      .timeOut       (timeOut)
   );

   always #20 clk = ~clk;

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
      if (actual !== expected)
      begin
         $display("ERROR at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   // a blank cell may still take any digit
   function automatic cellMask_t toMask(input int digit);
      cellMask_t m;
      if (digit == 0)
         m = '1;
      else
         m = cellMask_t'(1) << (digit - 1);
      return m;
   endfunction

   function automatic gridFlat_t packPuzzle();
      gridFlat_t g;
      for (int i = 0; i < N_CELLS; i++)
         g[i*N_DIGITS +: N_DIGITS] = toMask(puzzle[i]);
      return g;
   endfunction

   // next word of the vector file, lines starting with # are skipped
   task automatic readToken(output string tok, output bit ok);
      string rest;
      int    code;
      bit    done;
      ok   = 1'b0;
      done = 1'b0;
      while (!done)
      begin
         code = $fscanf(fd, "%s", tok);
         if (code != 1)
            done = 1'b1;
         else if (tok[0] == "#")
            code = $fgets(rest, fd);
         else
         begin
            ok   = 1'b1;
            done = 1'b1;
         end
      end
   endtask

   task automatic readGrid(input bit toSolution);
      string row;
      bit    ok;
      int    d;
      for (int r = 0; r < N_DIGITS; r++)
      begin
         readToken(row, ok);
         if (!ok || row.len() != N_DIGITS)
            abortRun($sformatf("vector file has a bad grid row in record %0d", recordCount));
         for (int c = 0; c < N_DIGITS; c++)
         begin
            d = row[c] - "0";
            if (d < 0 || d > N_DIGITS)
               abortRun($sformatf("vector file has a bad digit in record %0d", recordCount));
            if (toSolution)
               solution[r*N_DIGITS + c] = d;
            else
               puzzle[r*N_DIGITS + c] = d;
         end
      end
   endtask

   // pulse start, then check that the flags came back cleared
   task automatic startRun();
      @(posedge clk);
      #2;
      inGrid = packPuzzle();
      start  = 1'b1;
      @(posedge clk);
      #2;
      start  = 1'b0;
      inGrid = '0;
      checkValue(unsolvedCells, N_CELLS, "unsolvedCells after start");
      checkValue(allDone, 1'b0, "allDone after start");
      checkValue(anyChanged, 1'b0, "anyChanged after start");
      checkValue(anyError, 1'b0, "anyError after start");
      checkValue(timeOut, 1'b0, "timeOut after start");
   endtask

   task automatic waitForOutcome(input string flagName);
      int cycles;
      cycles = 0;
      while (!(allDone || anyError || timeOut))
      begin
         if (cycles == WAIT_LIMIT)
            abortRun($sformatf("timeout: %s never rose within %0d cycles, record %0d",
                               flagName, WAIT_LIMIT, recordCount));
         @(posedge clk);
         #2;
         cycles++;
      end
   endtask

   // full compare against the solution, or only the given cells
   task automatic checkGrid(input bit fullGrid);
      for (int i = 0; i < N_CELLS; i++)
      begin
         if (fullGrid)
            checkValue(outGrid[i*N_DIGITS +: N_DIGITS], toMask(solution[i]),
                       $sformatf("record %0d cell %0d", recordCount, i));
         else if (puzzle[i] != 0)
            checkValue(outGrid[i*N_DIGITS +: N_DIGITS], toMask(puzzle[i]),
                       $sformatf("record %0d given cell %0d", recordCount, i));
      end
   endtask

   initial
   begin
      string kind;
      bit    ok;
      int    gap;
      rst         = 1'b1;
      start       = 1'b0;
      inGrid      = '0;
      recordCount = 0;
      void'($urandom(SEED));
      fd = $fopen("bench/sudokuVectors.txt", "r");
      if (fd == 0)
         abortRun("could not open bench/sudokuVectors.txt for reading");

      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      checkValue(unsolvedCells, N_CELLS, "unsolvedCells after reset");
      checkValue(allDone, 1'b0, "allDone after reset");
      checkValue(anyChanged, 1'b0, "anyChanged after reset");
      checkValue(anyError, 1'b0, "anyError after reset");
      checkValue(timeOut, 1'b0, "timeOut after reset");

      readToken(kind, ok);
      while (ok)
      begin
         if (kind != "solve" && kind != "stall" && kind != "error")
            abortRun($sformatf("unknown record kind %s in the vector file", kind));
         readGrid(1'b0);
         if (kind == "solve")
            readGrid(1'b1);
         gap = $urandom_range(5, 0);
         repeat (gap) @(posedge clk);
         startRun();
         if (kind == "solve")
         begin
            waitForOutcome("allDone");
            checkValue(allDone, 1'b1, "allDone on a solvable puzzle");
            checkValue(timeOut, 1'b0, "timeOut on a solvable puzzle");
            checkValue(anyError, 1'b0, "anyError on a solvable puzzle");
            checkValue(unsolvedCells, 0, "unsolvedCells when done");
            checkGrid(1'b1);
         end
         else if (kind == "stall")
         begin
            waitForOutcome("timeOut");
            checkValue(timeOut, 1'b1, "timeOut on a stalled puzzle");
            checkValue(allDone, 1'b0, "allDone on a stalled puzzle");
            checkValue(anyError, 1'b0, "anyError on a stalled puzzle");
            checkValue(unsolvedCells != 0, 1'b1, "unsolved cells left in a stall");
            checkGrid(1'b0);
            startRun();  // restart while stalled
            waitForOutcome("timeOut");
            checkValue(timeOut, 1'b1, "timeOut after restart");
            checkValue(allDone, 1'b0, "allDone after restart");
         end
         else
         begin
            waitForOutcome("anyError");
            checkValue(anyError, 1'b1, "anyError on duplicate givens");
            checkValue(allDone, 1'b0, "allDone on duplicate givens");
         end
         recordCount++;
         readToken(kind, ok);
      end
      $fclose(fd);
      checkValue(recordCount != 0, 1'b1, "records read from the vector file");

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- bench/sudokuVectors.txt
# record: kind (solve, stall or error), then 9 rows of 9 puzzle digits, 0 is blank
# solve records then give 9 rows of the expected solution
solve
530070000
600195000
098000060
800060003
400803001
700020006
060000280
000419005
000080079
534678912
672195348
198342567
859761423
426853791
713924856
961537284
287419635
345286179
# transposed, digit d becomes 10 - d
solve
540263000
701000400
002000000
090020060
310408092
050070010
000000800
004000203
000794051
549263187
731589426
682147935
497321568
316458792
258976314
175632849
964815273
823794651
# three givens only
stall
100000000
000000000
000000000
000000000
000020000
000000000
000000000
000000000
000000003
# two fives in row 0 and box 0
error
535070000
600195000
098000060
800060003
400803001
700020006
060000280
000419005
000080079

//--- logic/groupChecker.sv
module groupChecker
   import sudokuPkg::*;
(
   input  cellMask_t cellMask [N_CELLS],
   output logic      groupError
);

   logic [N_GROUPS-1:0] groupBad;

   for (genvar g = 0; g < N_GROUPS; g++)
   begin : gGroup
      localparam int KIND = g / N_DIGITS;  // 0 row, 1 column, 2 box
      localparam int IDX  = g % N_DIGITS;

      cellMask_t member [N_DIGITS];
      cellMask_t seen;   // digits of solved cells so far
      logic      bad;

      for (genvar m = 0; m < N_DIGITS; m++)
      begin : gMember
         localparam int CELL =
            (KIND == 0) ? IDX * N_DIGITS + m :
            (KIND == 1) ? m * N_DIGITS + IDX :
            ((IDX / BOX) * BOX + m / BOX) * N_DIGITS + (IDX % BOX) * BOX + m % BOX;

         assign member[m] = cellMask[CELL];
      end

      always_comb
      begin
         seen = '0;
         bad  = 1'b0;
         for (int m = 0; m < N_DIGITS; m++)
         begin
            if (member[m] == '0)
               bad = 1'b1;  // no candidate left
            else if ($onehot(member[m]))
            begin
               if (|(seen & member[m]))
                  bad = 1'b1;
               seen = seen | member[m];
            end
         end
      end

      assign groupBad[g] = bad;
   end

   assign groupError = |groupBad;

endmodule

//--- logic/peerRouter.sv
module peerRouter
   import sudokuPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  cellMask_t  cellMask [N_CELLS],
   output peerMasks_t rowPeers [N_CELLS],
   output peerMasks_t colPeers [N_CELLS],
   output peerMasks_t boxPeers [N_CELLS]
);

   peerMasks_t rowNext [N_CELLS];
   peerMasks_t colNext [N_CELLS];
   peerMasks_t boxNext [N_CELLS];

   for (genvar c = 0; c < N_CELLS; c++)
   begin : gCell
      localparam int ROW     = c / N_DIGITS;
      localparam int COL     = c % N_DIGITS;
      localparam int BOX_ROW = (ROW / BOX) * BOX;  // top left corner of the box
      localparam int BOX_COL = (COL / BOX) * BOX;
      localparam int BOX_POS = (ROW % BOX) * BOX + COL % BOX;

      // k walks the group in cell order and steps over the cell itself
      for (genvar k = 0; k < N_PEERS; k++)
      begin : gPeer
         localparam int PEER_COL = (k < COL) ? k : k + 1;
         localparam int PEER_ROW = (k < ROW) ? k : k + 1;
         localparam int PEER_POS = (k < BOX_POS) ? k : k + 1;
         localparam int BOX_CELL = (BOX_ROW + PEER_POS / BOX) * N_DIGITS
                                   + BOX_COL + PEER_POS % BOX;

         assign rowNext[c][k] = cellMask[ROW * N_DIGITS + PEER_COL];
         assign colNext[c][k] = cellMask[PEER_ROW * N_DIGITS + COL];
         assign boxNext[c][k] = cellMask[BOX_CELL];
      end
   end

   // one register stage, cells see peers one cycle old
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rowPeers <= '{default: '0};
         colPeers <= '{default: '0};
         boxPeers <= '{default: '0};
      end
      else
      begin
         rowPeers <= rowNext;
         colPeers <= colNext;
         boxPeers <= boxNext;
      end
   end

endmodule

//--- logic/solverStatus.sv
module solverStatus
   import sudokuPkg::*;
#(
   parameter int STALL_LIMIT = 4
)
(
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  logic [N_CELLS-1:0] solved,
   input  logic [N_CELLS-1:0] changed,
   input  logic               groupError,
   output cellCount_t         unsolvedCells,
   output logic               allDone,
   output logic               anyChanged,
   output logic               anyError,
   output logic               timeOut
);

   localparam int               CNT_W   = $clog2(STALL_LIMIT + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(STALL_LIMIT);

   cellCount_t       unsolvedNext;
   logic             running;   // a grid has been loaded
   logic [CNT_W-1:0] stallCnt;

   // population count of unsolved cells
   always_comb
   begin
      unsolvedNext = '0;
      for (int i = 0; i < N_CELLS; i++)
         unsolvedNext = unsolvedNext + cellCount_t'(!solved[i]);
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         running       <= 1'b0;
         unsolvedCells <= cellCount_t'(N_CELLS);
         allDone       <= 1'b0;
         anyChanged    <= 1'b0;
         anyError      <= 1'b0;
         stallCnt      <= '0;
      end
      else if (start)
      begin
         running       <= 1'b1;
         unsolvedCells <= cellCount_t'(N_CELLS);
         allDone       <= 1'b0;
         anyChanged    <= 1'b0;
         anyError      <= 1'b0;
         stallCnt      <= '0;
      end
      else if (running)
      begin
         unsolvedCells <= unsolvedNext;
         allDone       <= &solved;
         anyChanged    <= |changed;
         anyError      <= groupError;
         if (anyChanged)
            stallCnt <= '0;
         else if (stallCnt != CNT_MAX)
            stallCnt <= stallCnt + 1'b1;  // saturates at the limit
      end
   end

   assign timeOut = (stallCnt == CNT_MAX);

endmodule

//--- logic/sudokuCell.sv
module sudokuCell
   import sudokuPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       start,
   input  cellMask_t  startValue,
   input  peerMasks_t rowPeers,
   input  peerMasks_t colPeers,
   input  peerMasks_t boxPeers,
   output cellMask_t  mask,
   output logic       solved,
   output logic       changed
);

   cellMask_t elimMask;    // digits held by solved peers
   cellMask_t rowUnion;
   cellMask_t colUnion;
   cellMask_t boxUnion;
   cellMask_t reduced;
   cellMask_t rowOnly;
   cellMask_t colOnly;
   cellMask_t boxOnly;
   cellMask_t maskNext;
   logic      peersStale;  // router still holds the previous grid

   assign solved = $onehot(mask);

   always_comb
   begin
      elimMask = '0;
      rowUnion = '0;
      colUnion = '0;
      boxUnion = '0;
      for (int k = 0; k < N_PEERS; k++)
      begin
         if ($onehot(rowPeers[k]))
            elimMask = elimMask | rowPeers[k];
         if ($onehot(colPeers[k]))
            elimMask = elimMask | colPeers[k];
         if ($onehot(boxPeers[k]))
            elimMask = elimMask | boxPeers[k];
         rowUnion = rowUnion | rowPeers[k];
         colUnion = colUnion | colPeers[k];
         boxUnion = boxUnion | boxPeers[k];
      end
   end

   assign reduced = mask & ~elimMask;

   // digits no other cell of the group can take
   assign rowOnly = reduced & ~rowUnion;
   assign colOnly = reduced & ~colUnion;
   assign boxOnly = reduced & ~boxUnion;

   always_comb
   begin
      if ($onehot(rowOnly))
         maskNext = rowOnly;
      else if ($onehot(colOnly))
         maskNext = colOnly;
      else if ($onehot(boxOnly))
         maskNext = boxOnly;
      else
         maskNext = reduced;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         mask       <= '0;
         peersStale <= 1'b0;
         changed    <= 1'b0;
      end
      else
      begin
         peersStale <= start;
         changed    <= 1'b0;
         if (start)
            mask <= startValue;
         else if (!peersStale && !solved)
         begin
            mask    <= maskNext;
            changed <= (maskNext != mask);
         end
      end
   end

endmodule

//--- logic/sudokuPkg.sv
package sudokuPkg;

   localparam int N_DIGITS = 9;   // also cells per group
   localparam int BOX      = 3;
   localparam int N_CELLS  = 81;
   localparam int N_PEERS  = 8;
   localparam int N_GROUPS = 27;  // rows, columns, boxes

   // bit d set means digit d+1 is still possible
   typedef logic [N_DIGITS-1:0] cellMask_t;

   typedef logic [6:0] cellCount_t;

   // cell 0 in the low bits, index is row * 9 + column
   typedef logic [N_CELLS*N_DIGITS-1:0] gridFlat_t;

   // other cells of one group, lowest cell index in element 0
   typedef cellMask_t [N_PEERS-1:0] peerMasks_t;

endpackage

//--- logic/sudokuSolver.sv
module sudokuSolver
   import sudokuPkg::*;
#(
   parameter int STALL_LIMIT = 4
)
(
   input  logic       clk,
   input  logic       rst,
   input  logic       start,
   input  gridFlat_t  inGrid,
   output gridFlat_t  outGrid,
   output cellCount_t unsolvedCells,
   output logic       allDone,
   output logic       anyChanged,
   output logic       anyError,
   output logic       timeOut
);

   cellMask_t          cellMask [N_CELLS];
   logic [N_CELLS-1:0] solved;
   logic [N_CELLS-1:0] changed;
   peerMasks_t         rowPeers [N_CELLS];
   peerMasks_t         colPeers [N_CELLS];
   peerMasks_t         boxPeers [N_CELLS];
   logic               groupError;

   for (genvar i = 0; i < N_CELLS; i++)
   begin : gCell
      sudokuCell uCell (
         .clk        (clk),
         .rst        (rst),
         .start      (start),
         .startValue (inGrid[i*N_DIGITS +: N_DIGITS]),
         .rowPeers   (rowPeers[i]),
         .colPeers   (colPeers[i]),
         .boxPeers   (boxPeers[i]),
         .mask       (cellMask[i]),
         .solved     (solved[i]),
         .changed    (changed[i])
      );
   end

   peerRouter uRouter (
      .clk      (clk),
      .rst      (rst),
      .cellMask (cellMask),
      .rowPeers (rowPeers),
      .colPeers (colPeers),
      .boxPeers (boxPeers)
   );

   groupChecker uChecker (
      .cellMask   (cellMask),
      .groupError (groupError)
   );

   solverStatus #(
      .STALL_LIMIT (STALL_LIMIT)
   ) uStatus (
      .clk           (clk),
      .rst           (rst),
      .start         (start),
      .solved        (solved),
      .changed       (changed),
      .groupError    (groupError),
      .unsolvedCells (unsolvedCells),
      .allDone       (allDone),
      .anyChanged    (anyChanged),
      .anyError      (anyError),
      .timeOut       (timeOut)
   );

   // cell 0 lands in the low bits
   always_comb
   begin
      for (int i = 0; i < N_CELLS; i++)
         outGrid[i*N_DIGITS +: N_DIGITS] = cellMask[i];
   end

endmodule

//--- sudokuSolver.f
logic/sudokuPkg.sv
logic/sudokuCell.sv
logic/peerRouter.sv
logic/groupChecker.sv
logic/solverStatus.sv
logic/sudokuSolver.sv
bench/sudokuSolverTb.sv
